// File: verilog.f
verilog/mem_stage_pkg.sv
verilog/mem_align.sv
verilog/mem_dcache.sv
verilog/mem_forward.sv
verilog/mem_stage.sv
sim/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - verilog/mem_stage_pkg.sv
      - verilog/mem_align.sv
      - verilog/mem_dcache.sv
      - verilog/mem_forward.sv
      - verilog/mem_stage.sv
  - target: test
    files:
      - sim/tb_mem_stage.sv

// File: sim/tb_mem_stage.sv
// ==========================================================
// testbench for the memory stage: random loads and stores,
// bus slave, reference model, bypass checks, watchdog
// ==========================================================

`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;
        import mem_stage_pkg::*;

        localparam int    n_ops = 400;
        localparam int    lines = 8;
        localparam addr_t base  = 32'h0000_1000;

        logic       clk;
        logic       rst_n;
        logic       access_req;
        mem_op_t    access;
        logic       access_ack;
        word_t      load_data;
        logic       access_error;
        gpr_idx_t   ex_rs1;
        gpr_idx_t   ex_rs2;
        word_t      rs1_reg_data;
        word_t      rs2_reg_data;
        reg_write_t mem_dst;
        reg_write_t wb_dst;
        word_t      rs1_data;
        word_t      rs2_data;
        logic       stall_ex;
        logic       bus_req;
        bus_req_t   bus;
        logic       bus_ack;
        word_t      bus_rdata;

        // reference model state
        word_t      model_mem [addr_t];
        word_t      slave_mem [addr_t];
        logic       shadow_valid [lines];
        addr_t      shadow_line [lines];
        bus_req_t   last_bus;
        int         bus_count;
        logic       prev_ack;
        logic       prev_req;
        logic       prev_bus;

        mem_stage #(
                .dcache_lines (lines)
        ) dut_i (
                .*
        );

        initial clk = 1'b0;
        always #10 clk = ~clk;

        task automatic expect_equal(input logic [63:0] actual, input logic [63:0] expected,
                                    input string what);
                if (actual !== expected) begin
                        $display("ERR %0t: %s mismatch, got %h expected %h",
                                 $time, what, actual, expected);
                        $display("test failed");
                        $fatal(1);
                end
        endtask

        // unwritten memory, distinct per dword
        function automatic word_t fill_pattern(addr_t da);
                return {da ^ 32'h5a5a_0f0f, ~da};
        endfunction

        function automatic logic [7:0] model_byte(addr_t a);
                addr_t da;
                word_t w;
                da = {a[31:3], 3'b000};
                w  = model_mem.exists(da) ? model_mem[da] : fill_pattern(da);
                return w[8*a[2:0] +: 8];
        endfunction

        function automatic word_t model_load(addr_t a, int nbytes, logic uns);
                word_t v;
                v = '0;
                for (int i = 0; i < nbytes; i++) begin
                        v[8*i +: 8] = model_byte(a + i);
                end
                if (!uns && nbytes < 8 && v[8*nbytes-1]) begin
                        v = v | ({64{1'b1}} << (8 * nbytes));
                end
                return v;
        endfunction

        function automatic void model_store(addr_t a, int nbytes, word_t data);
                addr_t da;
                word_t w;
                for (int i = 0; i < nbytes; i++) begin
                        da = {a[31:3] + ((a[2:0] + i) >> 3), 3'b000};
                        w  = model_mem.exists(da) ? model_mem[da] : fill_pattern(da);
                        w[8*((a + i) % 8) +: 8] = data[8*i +: 8];
                        model_mem[da] = w;
                end
        endfunction

        function automatic mem_op_t random_op(addr_t last_load);
                mem_op_t op;
                int      nbytes;
                op.write       = ($urandom % 3) == 0;
                op.size        = mem_size_e'($urandom % 4);
                op.is_unsigned = $urandom % 2;
                op.wdata       = {$urandom, $urandom};
                nbytes         = 1 << op.size;
                // reuse of a recent load line gives hits
                if (!op.write && ($urandom % 4) == 0) begin
                        op.addr = last_load & ~(nbytes - 1);
                end else begin
                        op.addr = (base + ($urandom % 256)) & ~(nbytes - 1);
                end
                if (nbytes > 1 && ($urandom % 10) == 0) begin
                        op.addr = op.addr + 1 + ($urandom % (nbytes - 1));
                end
                return op;
        endfunction

        function automatic reg_write_t random_dst(logic can_load);
                reg_write_t d;
                d.rd         = gpr_idx_t'($urandom % 8);
                d.write_gpr  = ($urandom % 4) != 0;
                d.mem_to_reg = can_load && ($urandom % 2);
                d.data       = {$urandom, $urandom};
                return d;
        endfunction

        // ==========================================================
        // forwarding model
        // ==========================================================
        function automatic logic needs_load(gpr_idx_t idx);
                return idx != 0 && mem_dst.write_gpr && mem_dst.rd == idx && mem_dst.mem_to_reg;
        endfunction

        function automatic word_t bypass_value(gpr_idx_t idx, word_t reg_val);
                if (idx != 0 && mem_dst.write_gpr && mem_dst.rd == idx) begin
                        return mem_dst.data;
                end
                if (idx != 0 && wb_dst.write_gpr && wb_dst.rd == idx) begin
                        return wb_dst.data;
                end
                return reg_val;
        endfunction

        task automatic check_source(input gpr_idx_t idx, input word_t reg_val, input word_t got,
                                    input word_t ld_val, input logic ld_known, input string what);
                if (needs_load(idx)) begin
                        if (access_ack && ld_known) begin
                                expect_equal(got, ld_val, what);
                        end
                end else begin
                        expect_equal(got, bypass_value(idx, reg_val), what);
                end
        endtask

        task automatic check_forward(input word_t ld_val, input logic ld_known);
                logic need;
                need = needs_load(ex_rs1) | needs_load(ex_rs2);
                expect_equal(stall_ex, need & !access_ack, "stall_ex");
                check_source(ex_rs1, rs1_reg_data, rs1_data, ld_val, ld_known, "rs1_data");
                check_source(ex_rs2, rs2_reg_data, rs2_data, ld_val, ld_known, "rs2_data");
        endtask

        // ==========================================================
        // one access through the four-phase port
        // ==========================================================
        task automatic run_op(input mem_op_t op);
                int         nbytes;
                logic       bad;
                logic       is_load;
                logic       is_hit;
                addr_t      da;
                int         idx;
                int         start_count;
                int         waited;
                word_t      exp_load;
                word_t      exp_lane;
                word_t      mask;
                logic [7:0] exp_strb;

                nbytes   = 1 << op.size;
                bad      = (op.addr % nbytes) != 0;
                is_load  = !op.write && !bad;
                da       = {op.addr[31:3], 3'b000};
                idx      = (da >> 3) % lines;
                is_hit   = shadow_valid[idx] && shadow_line[idx] == da;
                exp_load = model_load(op.addr, nbytes, op.is_unsigned);
                exp_strb = '0;
                exp_lane = '0;
                for (int i = 0; i < nbytes; i++) begin
                        exp_strb[(op.addr + i) % 8] = 1'b1;
                        exp_lane[8*((op.addr + i) % 8) +: 8] = op.wdata[8*i +: 8];
                end
                for (int b = 0; b < 8; b++) begin
                        mask[8*b +: 8] = {8{exp_strb[b]}};
                end

                @(posedge clk);
                start_count = bus_count;
                waited      = 0;
                access       <= op;
                access_req   <= 1'b1;
                ex_rs1       <= gpr_idx_t'($urandom % 8);
                ex_rs2       <= gpr_idx_t'($urandom % 8);
                rs1_reg_data <= {$urandom, $urandom};
                rs2_reg_data <= {$urandom, $urandom};
                mem_dst      <= random_dst(1'b1);
                wb_dst       <= random_dst(1'b0);
                do begin
                        @(negedge clk);
                        waited++;
                        check_forward(exp_load, is_load);
                end while (!access_ack);

                expect_equal(access_error, bad, "access_error");
                if (bad || (is_load && is_hit)) begin
                        expect_equal(waited, 2, "ack latency");
                        expect_equal(bus_count - start_count, 0, "bus transfer count");
                end else begin
                        expect_equal(bus_count - start_count, 1, "bus transfer count");
                        expect_equal(last_bus.write, op.write, "bus write");
                        expect_equal(last_bus.addr, da, "bus addr");
                end
                if (is_load) begin
                        expect_equal(load_data, exp_load, "load_data");
                        shadow_valid[idx] = 1'b1;
                        shadow_line[idx]  = da;
                end else if (!bad) begin
                        expect_equal(last_bus.wstrb, exp_strb, "bus wstrb");
                        expect_equal(last_bus.wdata & mask, exp_lane & mask, "bus wdata");
                        model_store(op.addr, nbytes, op.wdata);
                end

                @(posedge clk);
                access_req <= 1'b0;
                do begin
                        @(negedge clk);
                end while (access_ack);
        endtask

        // memory slave, 0 to 3 cycles before bus_ack
        always begin : slave
                int    delay;
                word_t w;
                @(posedge clk);
                if (rst_n && bus_req && !bus_ack) begin
                        delay = $urandom % 4;
                        repeat (delay) @(posedge clk);
                        last_bus = bus;
                        w = slave_mem.exists(bus.addr) ? slave_mem[bus.addr] :
                            fill_pattern(bus.addr);
                        if (bus.write) begin
                                for (int b = 0; b < 8; b++) begin
                                        if (bus.wstrb[b]) begin
                                                w[8*b +: 8] = bus.wdata[8*b +: 8];
                                        end
                                end
                                slave_mem[bus.addr] = w;
                        end else begin
                                bus_rdata <= w;
                        end
                        bus_ack <= 1'b1;
                        while (bus_req) @(posedge clk);
                        bus_ack <= 1'b0;
                end
        end

        // access port protocol and bus transfer count
        always @(negedge clk) begin
                if (rst_n) begin
                        if (access_ack && !prev_ack) begin
                                expect_equal(prev_req, 1'b1, "access_req under rising access_ack");
                        end
                        if (!access_ack && prev_ack) begin
                                expect_equal(prev_req, 1'b0, "access_req under falling access_ack");
                        end
                        if (bus_req && !prev_bus) begin
                                bus_count++;
                        end
                end
                prev_ack = access_ack;
                prev_req = access_req;
                prev_bus = bus_req;
        end

        initial begin
                #(n_ops * 20 * 20);
                $display("timeout: the accesses did not all complete in time");
                $display("test failed");
                $fatal(1);
        end

        initial begin
                mem_op_t op;
                addr_t   last_load;

                void'($urandom(44856));
                rst_n        <= 1'b0;
                access_req   <= 1'b0;
                access       <= '0;
                ex_rs1       <= '0;
                ex_rs2       <= '0;
                rs1_reg_data <= '0;
                rs2_reg_data <= '0;
                mem_dst      <= '0;
                wb_dst       <= '0;
                bus_ack      <= 1'b0;
                bus_rdata    <= '0;
                bus_count    = 0;
                for (int i = 0; i < lines; i++) begin
                        shadow_valid[i] = 1'b0;
                        shadow_line[i]  = '0;
                end
                repeat (3) @(posedge clk);
                rst_n <= 1'b1;
                @(negedge clk);
                expect_equal(access_ack, 1'b0, "access_ack after reset");
                expect_equal(bus_req, 1'b0, "bus_req after reset");

                last_load = base;
                for (int n = 0; n < n_ops; n++) begin
                        op = random_op(last_load);
                        if (!op.write) begin
                                last_load = op.addr;
                        end
                        run_op(op);
                end
                $display("test passed");
                $finish;
        end

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
// ==========================================================
// memory stage top: aligner, data cache, forwarding
// ==========================================================

`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
        parameter int dcache_lines = 16
) (
        input  wire logic                      clk,
        input  wire logic                      rst_n,
        // access port
        input  wire logic                      access_req,
        input  wire mem_stage_pkg::mem_op_t    access,
        output logic                           access_ack,
        output mem_stage_pkg::word_t           load_data,
        output logic                           access_error,
        // forwarding
        input  wire mem_stage_pkg::gpr_idx_t   ex_rs1,
        input  wire mem_stage_pkg::gpr_idx_t   ex_rs2,
        input  wire mem_stage_pkg::word_t      rs1_reg_data,
        input  wire mem_stage_pkg::word_t      rs2_reg_data,
        input  wire mem_stage_pkg::reg_write_t mem_dst,
        input  wire mem_stage_pkg::reg_write_t wb_dst,
        output mem_stage_pkg::word_t           rs1_data,
        output mem_stage_pkg::word_t           rs2_data,
        output logic                           stall_ex,
        // memory bus
        output logic                           bus_req,
        output mem_stage_pkg::bus_req_t        bus,
        input  wire logic                      bus_ack,
        input  wire mem_stage_pkg::word_t      bus_rdata
);
        import mem_stage_pkg::*;

        addr_t             line_addr;
        word_t             lane_wdata;
        logic [strb_w-1:0] lane_strb;
        logic              misaligned;
        word_t             line_rdata;

        mem_align align_i (
                .access      (access),
                .line_rdata  (line_rdata),
                .line_addr   (line_addr),
                .lane_wdata  (lane_wdata),
                .lane_strb   (lane_strb),
                .misaligned  (misaligned),
                .load_data   (load_data)
        );

        mem_dcache #(
                .dcache_lines (dcache_lines)
        ) dcache_i (
                .clk         (clk),
                .rst_n       (rst_n),
                .access_req  (access_req),
                .write       (access.write),
                .line_addr   (line_addr),
                .lane_wdata  (lane_wdata),
                .lane_strb   (lane_strb),
                .misaligned  (misaligned),
                .bus_ack     (bus_ack),
                .bus_rdata   (bus_rdata),
                .access_ack  (access_ack),
                .line_rdata  (line_rdata),
                .bus_req     (bus_req),
                .bus         (bus)
        );

        // error only reported alongside the ack
        assign access_error = misaligned & access_ack;

        mem_forward forward_i (
                .ex_rs1       (ex_rs1),
                .ex_rs2       (ex_rs2),
                .rs1_reg_data (rs1_reg_data),
                .rs2_reg_data (rs2_reg_data),
                .mem_dst      (mem_dst),
                .wb_dst       (wb_dst),
                .load_data    (load_data),
                .load_done    (access_ack),
                .rs1_data     (rs1_data),
                .rs2_data     (rs2_data),
                .stall_ex     (stall_ex)
        );

endmodule

`default_nettype wire

// File: verilog/mem_forward.sv
// ==========================================================
// EX operand bypass from MEM and WB, load-use stall
// ==========================================================

`timescale 1ns/100ps
`default_nettype none

module mem_forward (
        input  wire mem_stage_pkg::gpr_idx_t   ex_rs1,
        input  wire mem_stage_pkg::gpr_idx_t   ex_rs2,
        input  wire mem_stage_pkg::word_t      rs1_reg_data,
        input  wire mem_stage_pkg::word_t      rs2_reg_data,
        input  wire mem_stage_pkg::reg_write_t mem_dst,
        input  wire mem_stage_pkg::reg_write_t wb_dst,
        input  wire mem_stage_pkg::word_t      load_data,
        input  wire logic                      load_done,
        output mem_stage_pkg::word_t           rs1_data,
        output mem_stage_pkg::word_t           rs2_data,
        output logic                           stall_ex
);
        import mem_stage_pkg::*;

        localparam int n_src = 2;

        gpr_idx_t         src_idx [n_src];
        word_t            src_reg [n_src];
        word_t            src_fwd [n_src];
        logic [n_src-1:0] load_use;

        assign src_idx[0] = ex_rs1;
        assign src_idx[1] = ex_rs2;
        assign src_reg[0] = rs1_reg_data;
        assign src_reg[1] = rs2_reg_data;

        // MEM before WB before the register file, x0 never bypassed
        always_comb begin
                for (int i = 0; i < n_src; i++) begin
                        load_use[i] = 1'b0;
                        if (src_idx[i] != '0 && mem_dst.write_gpr &&
                            mem_dst.rd == src_idx[i]) begin
                                if (mem_dst.mem_to_reg) begin
                                        src_fwd[i]  = load_data;
                                        load_use[i] = !load_done;
                                end else begin
                                        src_fwd[i] = mem_dst.data;
                                end
                        end else if (src_idx[i] != '0 && wb_dst.write_gpr &&
                                     wb_dst.rd == src_idx[i]) begin
                                src_fwd[i] = wb_dst.data;
                        end else begin
                                src_fwd[i] = src_reg[i];
                        end
                end
        end

        assign rs1_data = src_fwd[0];
        assign rs2_data = src_fwd[1];

        // EX waits until the load in MEM returns
        assign stall_ex = |load_use;

        always_comb begin
                a_no_stall_on_done: assert final (!(stall_ex && load_done))
                        else $error("stall_ex high with load_done");
        end

endmodule

`default_nettype wire

// File: verilog/mem_dcache.sv
// ==========================================================
// direct-mapped write-through data cache, no write allocate
// request FSM and four-phase memory bus master
// ==========================================================

`timescale 1ns/100ps
`default_nettype none

module mem_dcache #(
        parameter int dcache_lines = 16
) (
        input  wire logic                             clk,
        input  wire logic                             rst_n,
        input  wire logic                             access_req,
        input  wire logic                             write,
        input  wire mem_stage_pkg::addr_t             line_addr,
        input  wire mem_stage_pkg::word_t             lane_wdata,
        input  wire logic [mem_stage_pkg::strb_w-1:0] lane_strb,
        input  wire logic                             misaligned,
        input  wire logic                             bus_ack,
        input  wire mem_stage_pkg::word_t             bus_rdata,
        output logic                                  access_ack,
        output mem_stage_pkg::word_t                  line_rdata,
        output logic                                  bus_req,
        output mem_stage_pkg::bus_req_t               bus
);
        import mem_stage_pkg::*;

        localparam int off_w = $clog2(strb_w);
        localparam int idx_w = $clog2(dcache_lines);
        localparam int tag_w = addr_w - off_w - idx_w;

        typedef enum logic [2:0] {
                st_idle,
                st_lookup,
                st_bus,
                st_wait_low,
                st_ack
        } state_e;

        state_e            state_q;
        logic [dcache_lines-1:0] valid_q;
        logic [tag_w-1:0]  tag_q [dcache_lines];
        word_t             data_q [dcache_lines];

        logic [idx_w-1:0]  idx;
        logic [tag_w-1:0]  tag;
        logic              hit;
        logic              fill;
        logic              store_hit;
        word_t             merged;

        assign idx        = line_addr[off_w +: idx_w];
        assign tag        = line_addr[addr_w-1 -: tag_w];
        assign hit        = valid_q[idx] && (tag_q[idx] == tag);
        assign line_rdata = data_q[idx];

        assign fill      = (state_q == st_bus) && bus_ack && !bus.write;
        assign store_hit = (state_q == st_lookup) && write && hit;

        // store bytes merged over the current line
        always_comb begin
                merged = data_q[idx];
                for (int b = 0; b < strb_w; b++) begin
                        if (lane_strb[b]) begin
                                merged[8*b +: 8] = lane_wdata[8*b +: 8];
                        end
                end
        end

        // ==========================================================
        // arrays
        // ==========================================================
        always_ff @(posedge clk) begin
                if (fill) begin
                        data_q[idx] <= bus_rdata;
                        tag_q[idx]  <= tag;
                end else if (store_hit) begin
                        data_q[idx] <= merged;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        valid_q <= '0;
                end else if (fill) begin
                        valid_q[idx] <= 1'b1;
                end
        end

        // ==========================================================
        // request FSM
        // ==========================================================
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state_q    <= st_idle;
                        access_ack <= 1'b0;
                        bus_req    <= 1'b0;
                end else begin
                        case (state_q)
                                st_idle: begin
                                        // misaligned and load hits answer next cycle
                                        if (access_req && (misaligned || (!write && hit))) begin
                                                access_ack <= 1'b1;
                                                state_q    <= st_ack;
                                        end else if (access_req) begin
                                                state_q <= st_lookup;
                                        end
                                end
                                st_lookup: begin
                                        bus_req <= 1'b1;
                                        state_q <= st_bus;
                                end
                                st_bus: begin
                                        if (bus_ack) begin
                                                bus_req <= 1'b0;
                                                state_q <= st_wait_low;
                                        end
                                end
                                st_wait_low: begin
                                        if (!bus_ack) begin
                                                access_ack <= 1'b1;
                                                state_q    <= st_ack;
                                        end
                                end
                                default: begin
                                        if (!access_req) begin
                                                access_ack <= 1'b0;
                                                state_q    <= st_idle;
                                        end
                                end
                        endcase
                end
        end

        // bus payload, held for the whole transfer
        always_ff @(posedge clk) begin
                if (state_q == st_lookup) begin
                        bus.write <= write;
                        bus.addr  <= line_addr;
                        bus.wdata <= lane_wdata;
                        bus.wstrb <= write ? lane_strb : '1;
                end
        end

        // ==========================================================
        // handshake checks
        // ==========================================================
        a_access_stable: assert property (@(posedge clk) disable iff (!rst_n)
                (access_req && !access_ack) |=>
                (!access_req || $stable({write, line_addr, lane_wdata, lane_strb})));

        a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
                bus_req |=> (!bus_req || $stable(bus)));

        a_bus_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
                $fell(bus_req) |-> $past(bus_ack));

endmodule

`default_nettype wire

// File: verilog/mem_align.sv
// ==========================================================
// store lane steering, load extraction, misalign check
// ==========================================================

`timescale 1ns/100ps
`default_nettype none

module mem_align (
        input  wire mem_stage_pkg::mem_op_t       access,
        input  wire mem_stage_pkg::word_t         line_rdata,
        output mem_stage_pkg::addr_t              line_addr,
        output mem_stage_pkg::word_t              lane_wdata,
        output logic [mem_stage_pkg::strb_w-1:0]  lane_strb,
        output logic                              misaligned,
        output mem_stage_pkg::word_t              load_data
);
        import mem_stage_pkg::*;

        localparam int off_w = $clog2(strb_w);

        logic [off_w-1:0]  offset;
        logic [strb_w-1:0] size_mask;
        word_t             lane_rdata;
        logic              ext;

        assign offset    = access.addr[off_w-1:0];
        assign line_addr = {access.addr[addr_w-1:off_w], {off_w{1'b0}}};

        // strobe pattern and alignment per size
        always_comb begin
                case (access.size)
                        size_byte: begin
                                size_mask  = 8'h01;
                                misaligned = 1'b0;
                        end
                        size_half: begin
                                size_mask  = 8'h03;
                                misaligned = offset[0];
                        end
                        size_word: begin
                                size_mask  = 8'h0f;
                                misaligned = |offset[1:0];
                        end
                        default: begin
                                size_mask  = 8'hff;
                                misaligned = |offset;
                        end
                endcase
        end

        assign lane_strb  = size_mask << offset;
        assign lane_wdata = access.wdata << {offset, 3'b000};

        // addressed bytes down to lane 0
        assign lane_rdata = line_rdata >> {offset, 3'b000};

        always_comb begin
                case (access.size)
                        size_byte: begin
                                ext       = ~access.is_unsigned & lane_rdata[7];
                                load_data = {{(xlen-8){ext}}, lane_rdata[7:0]};
                        end
                        size_half: begin
                                ext       = ~access.is_unsigned & lane_rdata[15];
                                load_data = {{(xlen-16){ext}}, lane_rdata[15:0]};
                        end
                        size_word: begin
                                ext       = ~access.is_unsigned & lane_rdata[31];
                                load_data = {{(xlen-32){ext}}, lane_rdata[31:0]};
                        end
                        default: begin
                                ext       = 1'b0;
                                load_data = lane_rdata;
                        end
                endcase
        end

endmodule

`default_nettype wire

// File: verilog/mem_stage_pkg.sv
// ==========================================================
// shared widths, access and bus structs, size encoding
// ==========================================================

`default_nettype none

package mem_stage_pkg;

        // ==========================================================
        // widths
        // ==========================================================
        localparam int xlen      = 64;
        localparam int addr_w    = 32;
        localparam int gpr_idx_w = 5;
        localparam int strb_w    = 8;

        typedef logic [xlen-1:0]      word_t;
        typedef logic [addr_w-1:0]    addr_t;
        typedef logic [gpr_idx_w-1:0] gpr_idx_t;

        // encoding is log2 of the access size in bytes
        typedef enum logic [1:0] {
                size_byte  = 2'd0,
                size_half  = 2'd1,
                size_word  = 2'd2,
                size_dword = 2'd3
        } mem_size_e;

        // ==========================================================
        // structs
        // ==========================================================

        // one load or store from the pipeline
        typedef struct packed {
                logic      write;
                mem_size_e size;
                logic      is_unsigned;
                addr_t     addr;
                // right aligned store data
                word_t     wdata;
        } mem_op_t;

        // one dword transfer on the memory bus
        typedef struct packed {
                logic              write;
                addr_t             addr;
                word_t             wdata;
                logic [strb_w-1:0] wstrb;
        } bus_req_t;

        // pending register write of a later stage
        typedef struct packed {
                gpr_idx_t rd;
                logic     write_gpr;
                logic     mem_to_reg;
                // alu result or written back value
                word_t    data;
        } reg_write_t;

endpackage

`default_nettype wire
